// File: testbench/div_cases.txt
// dividend divisor quotient remainder div0 ovf in hex
// quotient and remainder are zero where a flag is set
0064 07 0e 02 0 0
00ff 01 ff 00 0 0
feff ff ff fe 0 0
1234 56 36 10 0 0
7fff 80 ff 7f 0 0
0100 02 80 00 0 0
abcd c8 db b5 0 0
03e8 0a 64 00 0 0
0fa0 11 eb 05 0 0
00fe ff 00 fe 0 0
5a5a 5b fe 10 0 0
2710 64 64 00 0 0
c350 fa c8 00 0 0
4e20 9d 7f 3d 0 0
3039 3b d1 0e 0 0
8000 81 fe 02 0 0
00ff ff 01 00 0 0
7f80 80 ff 00 0 0
1234 00 00 00 1 1
0000 00 00 00 1 1
ffff 00 00 00 1 1
0100 01 00 00 0 1
ffff ff 00 00 0 1
8000 80 00 00 0 1
0500 03 00 00 0 1
7f00 7f 00 00 0 1

// File: sources.f
common/div_pkg.sv
div_core/div_uu.sv
rtl/div_queue.sv
rtl/div_ctrl.sv
rtl/div_unit_top.sv
testbench/div_unit_asserts.sv
testbench/tb_div_unit.sv

// File: Makefile
# Verilator build for the divide accelerator testbench
# run from the project root, the testbench reads testbench/div_cases.txt

VERILATOR ?= verilator
TOP       ?= tb_div_unit
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_ARGS  ?=

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)

// File: testbench/tb_div_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_div_unit;

	import div_pkg::*;

	localparam int random_count = 100;
	localparam int fill_limit   = 64; // more than both queues and the pipe hold

	logic        clk;
	logic        rst_n;
	logic [31:0] awaddr;
	logic        awvalid;
	logic        awready;
	logic [31:0] wdata;
	logic [3:0]  wstrb;
	logic        wvalid;
	logic        wready;
	logic [1:0]  bresp;
	logic        bvalid;
	logic        bready;
	logic [31:0] araddr;
	logic        arvalid;
	logic        arready;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	logic        rvalid;
	logic        rready;

	integer       seed = 32'hb84cdc8f;
	int           cycle_count = 0;
	int           cycle_limit = 0; // set once the cases are loaded
	div_operand_t case_ops[$];
	div_result_t  case_exp[$];
	div_result_t  pending[$];    // expected results in write order

	div_unit_top #(.queue_depth(8)) i_div_unit_top (.*);

	bind div_ctrl div_unit_asserts i_div_unit_asserts (
		.clk(clk), .rst_n(rst_n), .bvalid(bvalid), .bready(bready),
		.rvalid(rvalid), .rready(rready), .rdata(rdata),
		.op_pop(op_pop), .op_empty(op_empty),
		.res_push(res_push), .res_full(res_full), .ena(ena)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit)
		begin
			$display("timeout, the run did not end within %0d cycles", cycle_limit);
			$display("STATUS: FAIL");
			$fatal(1, "timeout");
		end
	end

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("STATUS: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp)
			stop_on_error($sformatf("CHECK FAILED %s: expected 0x%0h, got 0x%0h", name, exp, act));
	endtask

	task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
		check_word(name, 32'(exp), 32'(act));
	endtask

	task automatic check_status(input logic [1:0] exp, input logic [1:0] act);
		check_word("status[1:0]", 32'(exp), 32'(act));
	endtask

	task automatic check_result(input string name, input div_result_t exp, input div_result_t act);
		check_word({name, ".div0"}, 32'(exp.div0), 32'(act.div0));
		check_word({name, ".ovf"}, 32'(exp.ovf), 32'(act.ovf));
		// q and s carry no meaning once a flag is up
		if (!exp.div0 && !exp.ovf)
		begin
			check_word({name, ".q"}, 32'(exp.q), 32'(act.q));
			check_word({name, ".s"}, 32'(exp.s), 32'(act.s));
		end
	endtask

	// entered and left 1 ns after a rising edge
	task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
		output logic [1:0] resp);
		awaddr  = addr;
		wdata   = data;
		wstrb   = 4'hf;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		while (!awready)
		begin
			@(posedge clk);
			#1;
		end
		check_word("wready", 32'h1, 32'(wready));
		@(posedge clk); // handshake edge
		#1;
		awvalid = 1'b0;
		wvalid  = 1'b0;
		while (!bvalid)
		begin
			@(posedge clk);
			#1;
		end
		@(posedge clk); // bvalid waits one cycle for bready
		#1;
		resp   = bresp;
		bready = 1'b1;
		@(posedge clk);
		#1;
		bready = 1'b0;
	endtask

	task automatic axi_read(input logic [31:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		araddr  = addr;
		arvalid = 1'b1;
		while (!arready)
		begin
			@(posedge clk);
			#1;
		end
		@(posedge clk);
		#1;
		arvalid = 1'b0;
		while (!rvalid)
		begin
			@(posedge clk);
			#1;
		end
		@(posedge clk); // rvalid waits one cycle for rready
		#1;
		data   = rdata;
		resp   = rresp;
		rready = 1'b1;
		@(posedge clk);
		#1;
		rready = 1'b0;
	endtask

	// reference arithmetic from the register map rules
	function automatic div_result_t expected_result(input div_operand_t op);
		div_result_t res;
		logic [15:0] quo;
		logic [15:0] rem;
		res      = '0;
		res.div0 = (op.d == 8'd0);
		res.ovf  = (op.z[15:8] >= op.d); // quotient would not fit in 8 bits
		if (!res.ovf)
		begin
			quo   = op.z / {8'd0, op.d};
			rem   = op.z % {8'd0, op.d};
			res.q = quo[7:0];
			res.s = rem[7:0];
		end
		return res;
	endfunction

	function automatic div_result_t result_from_word(input logic [31:0] word);
		div_result_t res;
		res.q    = word[7:0];
		res.s    = word[15:8];
		res.div0 = word[16];
		res.ovf  = word[17];
		return res;
	endfunction

	// nonzero divisor, upper dividend half below it
	function automatic div_operand_t random_operand();
		logic [31:0]  r;
		div_operand_t op;
		r    = $random(seed);
		op.d = (r[7:0] == 8'd0) ? 8'd1 : r[7:0];
		op.z = {r[15:8] % op.d, r[23:16]};
		return op;
	endfunction

	// poll reg_result until bit 31 shows a result
	task automatic await_result(output div_result_t res);
		logic [31:0] data;
		logic [1:0]  resp;
		data = '0;
		while (!data[31])
		begin
			axi_read(reg_result, data, resp);
			check_resp("rresp", resp_okay, resp);
		end
		check_word("rdata[30:18]", 32'h0, {19'h0, data[30:18]});
		res = result_from_word(data);
	endtask

	task automatic load_cases();
		int           fd;
		int           n;
		string        line;
		logic [31:0]  f [6];
		div_operand_t op;
		div_result_t  res;
		fd = $fopen("testbench/div_cases.txt", "r");
		if (fd == 0)
			stop_on_error("cannot open testbench/div_cases.txt");
		while ($fgets(line, fd) > 0)
		begin
			n = $sscanf(line, "%h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5]);
			if (n == 6)
			begin
				op.z     = f[0][15:0];
				op.d     = f[1][7:0];
				res.q    = f[2][7:0];
				res.s    = f[3][7:0];
				res.div0 = f[4][0];
				res.ovf  = f[5][0];
				case_ops.push_back(op);
				case_exp.push_back(res);
			end
			else if (n > 0)
				stop_on_error({"malformed line in case file: ", line});
		end
		$fclose(fd);
	endtask

	initial
	begin
		div_operand_t op;
		div_result_t  res;
		logic [31:0]  data;
		logic [1:0]   resp;
		int           accepted;
		int           drained;
		bit           refused;

		rst_n   = 1'b0;
		awaddr  = '0;
		awvalid = 1'b0;
		wdata   = '0;
		wstrb   = '0;
		wvalid  = 1'b0;
		bready  = 1'b0;
		araddr  = '0;
		arvalid = 1'b0;
		rready  = 1'b0;

		load_cases();
		if (case_ops.size() == 0)
			stop_on_error("the case file holds no cases");
		cycle_limit = 200 * (case_ops.size() + fill_limit + random_count + 16);

		repeat (16) @(posedge clk);
		#1 rst_n = 1'b1;
		@(posedge clk);
		#1;

		// empty result queue and an unmapped offset
		axi_read(reg_status, data, resp);
		check_resp("rresp", resp_okay, resp);
		check_status(2'b10, data[1:0]);
		axi_read(reg_result, data, resp);
		check_resp("rresp", resp_okay, resp);
		check_word("rdata", 32'h0, data);
		axi_read(32'h0c, data, resp);
		check_resp("rresp", resp_slverr, resp);
		axi_write(32'h0c, 32'h0001_0001, resp);
		check_resp("bresp", resp_slverr, resp);
		// a wrong push would reach the result queue within the pipe latency
		repeat (div_d_width + 1)
		begin
			axi_read(reg_result, data, resp);
			check_resp("rresp", resp_okay, resp);
			check_word("rdata", 32'h0, data);
		end

		foreach (case_ops[i])
		begin
			axi_write(reg_operands, {8'h00, case_ops[i].d, case_ops[i].z}, resp);
			check_resp("bresp", resp_okay, resp);
			await_result(res);
			check_result($sformatf("case %0d result", i), case_exp[i], res);
		end

		// back-pressure, write until the operand queue refuses
		accepted = 0;
		refused  = 1'b0;
		while (!refused && accepted < fill_limit)
		begin
			op = random_operand();
			axi_write(reg_operands, {8'h00, op.d, op.z}, resp);
			if (resp == resp_okay)
			begin
				pending.push_back(expected_result(op));
				accepted++;
			end
			else
			begin
				check_resp("bresp", resp_slverr, resp);
				refused = 1'b1;
			end
		end
		if (!refused)
			stop_on_error("no operand write was refused, the operand queue never filled");
		axi_read(reg_status, data, resp);
		check_status(2'b01, data[1:0]);

		drained = 0;
		data    = 32'h8000_0000;
		while (data[31])
		begin
			axi_read(reg_result, data, resp);
			check_resp("rresp", resp_okay, resp);
			if (data[31])
			begin
				if (pending.size() == 0)
					stop_on_error("more results came back than writes were accepted");
				check_result("drained result", pending.pop_front(), result_from_word(data));
				drained++;
			end
		end
		check_word("result count", 32'(accepted), 32'(drained));

		repeat (random_count)
		begin
			op = random_operand();
			axi_write(reg_operands, {8'h00, op.d, op.z}, resp);
			check_resp("bresp", resp_okay, resp);
			await_result(res);
			check_result("random result", expected_result(op), res);
		end

		if (pending.size() == 0)
		begin
			$display("STATUS: PASS");
			$finish;
		end
		else
		begin
			$display("STATUS: FAIL");
			$fatal(1, "expected results left over");
		end
	end

endmodule

`default_nettype wire

// File: testbench/div_unit_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module div_unit_asserts (
	input wire        clk,
	input wire        rst_n,
	input wire        bvalid,
	input wire        bready,
	input wire        rvalid,
	input wire        rready,
	input wire [31:0] rdata,
	input wire        op_pop,
	input wire        op_empty,
	input wire        res_push,
	input wire        res_full,
	input wire        ena
);

	// response channels hold until the host takes them
	bvalid_held: assert property (@(posedge clk) disable iff (!rst_n)
		(bvalid && !bready) |=> bvalid)
		else $error("bvalid dropped before bready");

	rvalid_held: assert property (@(posedge clk) disable iff (!rst_n)
		(rvalid && !rready) |=> (rvalid && $stable(rdata)))
		else $error("rvalid or rdata changed before rready");

	no_res_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		!(res_push && res_full))
		else $error("result queue pushed while full");

	no_op_underflow: assert property (@(posedge clk) disable iff (!rst_n)
		!(op_pop && op_empty))
		else $error("operand queue popped while empty");

	// whole pipe frozen while results cannot leave
	stall_on_full: assert property (@(posedge clk) disable iff (!rst_n)
		res_full |-> !ena)
		else $error("divider enabled with the result queue full");

endmodule

`default_nettype wire

// File: rtl/div_unit_top.sv
`timescale 1ns/1ps
`default_nettype none

module div_unit_top #(
	parameter int queue_depth = 8
) (
	input  wire        clk,
	input  wire        rst_n,
	input  wire [31:0] awaddr,
	input  wire        awvalid,
	output logic       awready,
	input  wire [31:0] wdata,
	input  wire [3:0]  wstrb,
	input  wire        wvalid,
	output logic       wready,
	output logic [1:0] bresp,
	output logic       bvalid,
	input  wire        bready,
	input  wire [31:0] araddr,
	input  wire        arvalid,
	output logic       arready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output logic       rvalid,
	input  wire        rready
);

	import div_pkg::*;

	logic         op_push;
	div_operand_t op_data;
	logic         op_full;
	logic         op_pop;
	logic         op_empty;
	div_operand_t op_head;
	logic         ena;
	logic         in_valid;
	div_operand_t in_operand;
	logic         out_valid;
	div_result_t  out_result;
	logic         res_push;
	div_result_t  res_data;
	logic         res_full;
	logic         res_pop;
	logic         res_empty;
	div_result_t  res_head;

	div_ctrl i_div_ctrl (
		.clk, .rst_n,
		.awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
		.bresp, .bvalid, .bready,
		.araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
		.op_push, .op_data, .op_full, .op_pop, .op_empty, .op_head,
		.ena, .in_valid, .in_operand, .out_valid, .out_result,
		.res_push, .res_data, .res_full, .res_pop, .res_empty, .res_head
	);

	div_queue #(.payload_t(div_operand_t), .queue_depth(queue_depth)) i_op_queue (
		.clk, .rst_n,
		.push(op_push), .push_data(op_data), .pop(op_pop),
		.head(op_head), .full(op_full), .empty(op_empty)
	);

	div_uu #(.z_width(div_z_width)) i_div_uu (
		.clk, .rst_n, .ena, .in_valid, .in_operand, .out_valid, .out_result
	);

	div_queue #(.payload_t(div_result_t), .queue_depth(queue_depth)) i_res_queue (
		.clk, .rst_n,
		.push(res_push), .push_data(res_data), .pop(res_pop),
		.head(res_head), .full(res_full), .empty(res_empty)
	);

endmodule

`default_nettype wire

// File: rtl/div_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module div_ctrl (
	input  wire                        clk,
	input  wire                        rst_n,
	// AXI4-Lite slave
	input  wire [31:0]                 awaddr,
	input  wire                        awvalid,
	output logic                       awready,
	input  wire [31:0]                 wdata,
	input  wire [3:0]                  wstrb,
	input  wire                        wvalid,
	output logic                       wready,
	output logic [1:0]                 bresp,
	output logic                       bvalid,
	input  wire                        bready,
	input  wire [31:0]                 araddr,
	input  wire                        arvalid,
	output logic                       arready,
	output logic [31:0]                rdata,
	output logic [1:0]                 rresp,
	output logic                       rvalid,
	input  wire                        rready,
	// operand queue
	output logic                       op_push,
	output div_pkg::div_operand_t      op_data,
	input  wire                        op_full,
	output logic                       op_pop,
	input  wire                        op_empty,
	input  wire div_pkg::div_operand_t op_head,
	// divider
	output logic                       ena,
	output logic                       in_valid,
	output div_pkg::div_operand_t      in_operand,
	input  wire                        out_valid,
	input  wire div_pkg::div_result_t  out_result,
	// result queue
	output logic                       res_push,
	output div_pkg::div_result_t       res_data,
	input  wire                        res_full,
	output logic                       res_pop,
	input  wire                        res_empty,
	input  wire div_pkg::div_result_t  res_head
);

	import div_pkg::*;

	typedef enum logic [1:0] {
		ch_idle,
		ch_accept, // ready high for one cycle
		ch_resp    // valid held until the host takes it
	} ch_state_t;

	ch_state_t   wr_state;
	ch_state_t   rd_state;
	logic        wr_is_operands;
	logic        wr_lanes_ok;
	logic [1:0]  wr_code;
	logic [31:0] rd_word;
	logic [1:0]  rd_code;

	// write channel
	assign awready = (wr_state == ch_accept);
	assign wready  = (wr_state == ch_accept);
	assign bvalid  = (wr_state == ch_resp);

	assign wr_is_operands = (awaddr == reg_operands);
	assign wr_lanes_ok    = &wstrb[2:0]; // z and d lanes all written
	assign op_data        = '{z: wdata[15:0], d: wdata[23:16]};
	assign op_push        = awready && wr_is_operands && wr_lanes_ok && !op_full;
	assign wr_code        = op_push ? resp_okay : resp_slverr;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			wr_state <= ch_idle;
		else
		begin
			case (wr_state)
				ch_idle:
					if (awvalid && wvalid)
						wr_state <= ch_accept;
				ch_accept:
				begin
					bresp    <= wr_code;
					wr_state <= ch_resp;
				end
				default:
					if (bready)
						wr_state <= ch_idle;
			endcase
		end
	end

	// read channel
	assign arready = (rd_state == ch_accept);
	assign rvalid  = (rd_state == ch_resp);
	assign res_pop = arready && (araddr == reg_result) && !res_empty;

	always_comb
	begin
		rd_word = '0;
		rd_code = resp_okay;
		if (araddr == reg_status)
			rd_word = {30'b0, res_empty, op_full};
		else if (araddr == reg_result)
		begin
			if (!res_empty)
				rd_word = {1'b1, 13'b0, res_head}; // bit 31 marks a result
		end
		else
			rd_code = resp_slverr;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			rd_state <= ch_idle;
		else
		begin
			case (rd_state)
				ch_idle:
					if (arvalid)
						rd_state <= ch_accept;
				ch_accept:
				begin
					rdata    <= rd_word;
					rresp    <= rd_code;
					rd_state <= ch_resp;
				end
				default:
					if (rready)
						rd_state <= ch_idle;
			endcase
		end
	end

	// pipe runs while the result queue has room
	assign ena        = !res_full;
	assign op_pop     = ena && !op_empty;
	assign in_valid   = op_pop;
	assign in_operand = op_head;
	assign res_push   = ena && out_valid;
	assign res_data   = out_result;

endmodule

`default_nettype wire

// File: rtl/div_queue.sv
`timescale 1ns/1ps
`default_nettype none

module div_queue #(
	parameter type payload_t   = logic [7:0],
	parameter int  queue_depth = 8
) (
	input  wire           clk,
	input  wire           rst_n,
	input  wire           push,
	input  wire payload_t push_data,
	input  wire           pop,
	output payload_t      head,
	output logic          full,
	output logic          empty
);

	localparam int aw = $clog2(queue_depth);

	payload_t        mem [queue_depth];
	logic [aw:0]     wr_ptr; // extra msb tells full from empty
	logic [aw:0]     rd_ptr;

	// storage has no reset, only the pointers
	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr[aw-1:0]] <= push_data;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	assign head  = mem[rd_ptr[aw-1:0]]; // valid while not empty
	assign empty = (wr_ptr == rd_ptr);
	// same index, wrapped a different number of times
	assign full  = (wr_ptr[aw] != rd_ptr[aw]) && (wr_ptr[aw-1:0] == rd_ptr[aw-1:0]);

endmodule

`default_nettype wire

// File: div_core/div_uu.sv
`timescale 1ns/1ps
`default_nettype none

module div_uu #(
	parameter int z_width = 16
) (
	input  wire                       clk,
	input  wire                       rst_n,
	input  wire                       ena,        // freezes every stage when low
	input  wire                       in_valid,
	input  wire div_pkg::div_operand_t in_operand,
	output logic                      out_valid,
	output div_pkg::div_result_t      out_result
);

	import div_pkg::*;

	localparam int d_width = z_width / 2;

	// shift, then add or subtract depending on the sign
	function automatic logic [z_width:0] gen_s(input logic [z_width:0] si,
		input logic [z_width:0] di);
		logic [z_width:0] shifted;
		shifted = {si[z_width-1:0], 1'b0};
		if (si[z_width])
			gen_s = shifted + di;
		else
			gen_s = shifted - di;
	endfunction

	// append one quotient bit, set when the new remainder is not negative
	function automatic logic [d_width-1:0] gen_q(input logic [d_width-1:0] qi,
		input logic [z_width:0] si);
		gen_q = {qi[d_width-2:0], ~si[z_width]};
	endfunction

	// final correction of a negative remainder
	function automatic logic [d_width-1:0] assign_s(input logic [z_width:0] si,
		input logic [z_width:0] di);
		logic [z_width:0] tmp;
		if (si[z_width])
			tmp = si + di;
		else
			tmp = si;
		assign_s = tmp[z_width-1:z_width-d_width];
	endfunction

	logic [z_width:0]   s_in;
	logic [z_width:0]   d_in;
	logic               div0_in;
	logic               ovf_in;

	logic [z_width:0]   s_pipe    [1:d_width];
	logic [z_width:0]   d_pipe    [1:d_width];
	logic [d_width-1:0] q_pipe    [1:d_width-1]; // lags s_pipe by one stage
	logic               div0_pipe [1:d_width];
	logic               ovf_pipe  [1:d_width];
	logic [d_width:1]   valid_pipe;

	// entry stage, divisor aligned to the upper dividend half
	assign s_in    = {1'b0, in_operand.z};
	assign d_in    = {1'b0, in_operand.d, {(z_width-d_width){1'b0}}};
	assign div0_in = ~|in_operand.d;
	assign ovf_in  = !(in_operand.z[z_width-1:d_width] < in_operand.d);

	// data stages
	always_ff @(posedge clk)
	begin
		if (ena)
		begin
			s_pipe[1]    <= gen_s(s_in, d_in);
			d_pipe[1]    <= d_in;
			div0_pipe[1] <= div0_in;
			ovf_pipe[1]  <= ovf_in;
			q_pipe[1]    <= gen_q('0, s_pipe[1]);
			for (int n = 2; n <= d_width; n++)
			begin
				s_pipe[n]    <= gen_s(s_pipe[n-1], d_pipe[n-1]);
				d_pipe[n]    <= d_pipe[n-1];
				div0_pipe[n] <= div0_pipe[n-1];
				ovf_pipe[n]  <= ovf_pipe[n-1];
			end
			for (int n = 2; n < d_width; n++)
				q_pipe[n] <= gen_q(q_pipe[n-1], s_pipe[n]);

			// output register, the ninth enabled cycle
			out_result.q    <= gen_q(q_pipe[d_width-1], s_pipe[d_width]);
			out_result.s    <= assign_s(s_pipe[d_width], d_pipe[d_width]);
			out_result.div0 <= div0_pipe[d_width];
			out_result.ovf  <= ovf_pipe[d_width];
		end
	end

	// valid travels alongside the data
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			valid_pipe <= '0;
			out_valid  <= 1'b0;
		end
		else if (ena)
		begin
			valid_pipe <= {valid_pipe[d_width-1:1], in_valid};
			out_valid  <= valid_pipe[d_width];
		end
	end

endmodule

`default_nettype wire

// File: common/div_pkg.sv
`default_nettype none

package div_pkg;

	// operand widths, the dividend is twice the divisor
	localparam int div_z_width = 16;
	localparam int div_d_width = 8;

	// AXI4-Lite register byte offsets
	localparam logic [31:0] reg_operands = 32'h00;
	localparam logic [31:0] reg_status   = 32'h04;
	localparam logic [31:0] reg_result   = 32'h08;

	// AXI response codes
	localparam logic [1:0] resp_okay   = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

	// one divide request, 24 bits
	typedef struct packed {
		logic [div_z_width-1:0] z; // dividend
		logic [div_d_width-1:0] d; // divisor
	} div_operand_t;

	// one divide result, 18 bits
	// field order matches the reg_result read layout from bit 17 down
	typedef struct packed {
		logic                   ovf;  // upper dividend half not below divisor
		logic                   div0; // divisor was zero
		logic [div_d_width-1:0] s;    // remainder
		logic [div_d_width-1:0] q;    // quotient
	} div_result_t;

endpackage

`default_nettype wire
